//--- hw/approxMulPkg.sv
package approxMulPkg;

    // Operand and result widths
    localparam int OperandWidth = 8;
    localparam int ProductWidth = 2 * OperandWidth;

    // Columns up to this one use approximate cells
    localparam int ApproxTopColumn = 7;

    typedef logic [OperandWidth-1:0] operandT;
    typedef logic [ProductWidth-1:0] productT;

    // Row i is multiplier bit i ANDed with the multiplicand
    typedef operandT [OperandWidth-1:0] ppArrayT;

    // Propagate/generate of mirrored pairs, grouped by the higher row
    typedef struct packed {
        logic [4:0] p7;
        logic [4:0] g7;
        logic [5:0] p6;
        logic [5:0] g6;
        logic [4:0] p5;
        logic [4:0] g5;
        logic [3:0] p4;
        logic [3:0] g4;
        logic [2:0] p3;
        logic [2:0] g3;
        // Row 2 column 1 paired with row 1 column 2
        logic       p21;
        logic       g21;
    } pgColumnsT;

    // Two rows left for the final adder
    typedef struct packed {
        productT sumRow;
        productT carryRow;
    } rowPairT;

    typedef struct packed {
        operandT multiplicand;
        operandT multiplier;
        logic    valid;
    } mulReqT;

endpackage

//--- hw/approxCellPkg.sv
package approxCellPkg;

    // Sum and carry of a single adder cell
    typedef struct packed {
        logic carry;
        logic sum;
    } cellOutT;

    // 4:2 compressor adds a lateral carry out
    typedef struct packed {
        logic carryOut;
        logic carry;
        logic sum;
    } compress42OutT;

    ////////////////////////////////////////////////////////////
    // Exact cells
    ////////////////////////////////////////////////////////////

    function automatic cellOutT exactHalfAdd(input logic a, input logic b);
        cellOutT res;
        res.sum   = a ^ b;
        res.carry = a & b;
        return res;
    endfunction

    function automatic cellOutT exactFullAdd(input logic a, input logic b, input logic cin);
        cellOutT res;
        logic    halfSum;
        halfSum   = a ^ b;
        res.sum   = halfSum ^ cin;
        res.carry = (a & b) | (halfSum & cin);
        return res;
    endfunction

    // Two chained full adders
    function automatic compress42OutT exactCompress42(input logic x1, input logic x2,
                                                      input logic x3, input logic x4,
                                                      input logic cin);
        cellOutT       first;
        cellOutT       second;
        compress42OutT res;
        first        = exactFullAdd(x1, x2, x3);
        second       = exactFullAdd(first.sum, x4, cin);
        res.sum      = second.sum;
        res.carry    = second.carry;
        // First stage carry goes sideways to the next column
        res.carryOut = first.carry;
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // Approximate cells
    ////////////////////////////////////////////////////////////

    // OR for sum, wrong only when both inputs set
    function automatic cellOutT approxHalfAdd(input logic a, input logic b);
        cellOutT res;
        res.sum   = a | b;
        res.carry = a & b;
        return res;
    endfunction

    function automatic cellOutT approxFullAdd(input logic a, input logic b, input logic cin);
        cellOutT res;
        logic    w;
        // a and b collapse to one bit
        w         = a | b;
        res.sum   = w ^ cin;
        res.carry = w & cin;
        return res;
    endfunction

    // Probabilistic 4-input compressor
    function automatic cellOutT pacCompress(input logic x1, input logic x2,
                                            input logic x3, input logic x4);
        cellOutT res;
        logic    lowPair;
        logic    highPair;
        lowPair   = x1 & x2;
        highPair  = x3 & x4;
        // Carry only from matching pairs
        res.carry = lowPair | highPair;
        res.sum   = (x1 ^ x2) | (x3 ^ x4) | (lowPair & highPair);
        return res;
    endfunction

endpackage

//--- hw/partialProductGen.sv
`timescale 1ns/1ps

module partialProductGen import approxMulPkg::*; #(
    parameter int OperandWidth = approxMulPkg::OperandWidth
) (
    input  operandT   multiplicand,
    input  operandT   multiplier,
    output ppArrayT   ppArray,
    output pgColumnsT pgColumns
);

    // AND array
    for (genvar i = 0; i < OperandWidth; i++) begin : gRow
        // Row i gated by multiplier bit i
        assign ppArray[i] = multiplicand & {OperandWidth{multiplier[i]}};
    end

    // Mirrored pairs recoded to OR and AND
    // a + b equals (a | b) + (a & b) in the same column
    always_comb begin
        // Row 7 against rows 0 to 4
        for (int j = 0; j < $bits(pgColumns.p7); j++) begin
            pgColumns.p7[j] = ppArray[7][j] | ppArray[j][7];
            pgColumns.g7[j] = ppArray[7][j] & ppArray[j][7];
        end
        // Row 6 against rows 0 to 5
        for (int j = 0; j < $bits(pgColumns.p6); j++) begin
            pgColumns.p6[j] = ppArray[6][j] | ppArray[j][6];
            pgColumns.g6[j] = ppArray[6][j] & ppArray[j][6];
        end
        for (int j = 0; j < $bits(pgColumns.p5); j++) begin
            pgColumns.p5[j] = ppArray[5][j] | ppArray[j][5];
            pgColumns.g5[j] = ppArray[5][j] & ppArray[j][5];
        end
        for (int j = 0; j < $bits(pgColumns.p4); j++) begin
            pgColumns.p4[j] = ppArray[4][j] | ppArray[j][4];
            pgColumns.g4[j] = ppArray[4][j] & ppArray[j][4];
        end
        for (int j = 0; j < $bits(pgColumns.p3); j++) begin
            pgColumns.p3[j] = ppArray[3][j] | ppArray[j][3];
            pgColumns.g3[j] = ppArray[3][j] & ppArray[j][3];
        end
        // Single pair in column 3
        pgColumns.p21 = ppArray[2][1] | ppArray[1][2];
        pgColumns.g21 = ppArray[2][1] & ppArray[1][2];
    end

endmodule

//--- hw/columnReduction.sv
`timescale 1ns/1ps

module columnReduction import approxMulPkg::*; import approxCellPkg::*; #(
    parameter int ApproxTopColumn = approxMulPkg::ApproxTopColumn
) (
    input  ppArrayT   ppArray,
    input  pgColumnsT pgColumns,
    output rowPairT   rows
);

    // Low column cells
    cellOutT aha2;
    cellOutT aha4;
    cellOutT afa5;
    cellOutT pac6;
    cellOutT pac7;
    logic    gen3;
    logic    gen4;
    logic    gen5;
    logic    gen6;
    logic    gen7;

    // High column cells
    cellOutT       ha12;
    cellOutT       gen11;
    cellOutT       ha11;
    cellOutT       gen10;
    cellOutT       fa10;
    cellOutT       gen9;
    cellOutT       fa9;
    cellOutT       gen8;
    compress42OutT cmp8;

    // Carry resolve chain
    cellOutT res8;
    cellOutT res9;
    cellOutT res10;
    cellOutT res11;
    cellOutT res12;

    // Last stage, one cell per column
    cellOutT row3;
    cellOutT row4;
    cellOutT row5;
    cellOutT row6;
    cellOutT row7;
    cellOutT row8;
    cellOutT row9;
    cellOutT row10;
    cellOutT row11;
    cellOutT row12;
    cellOutT row13;
    cellOutT row14;

    logic [ApproxTopColumn:0]              lowSum;
    logic [ApproxTopColumn:0]              lowCarry;
    logic [ProductWidth-1:ApproxTopColumn+1] highSum;
    logic [ProductWidth-1:ApproxTopColumn+1] highCarry;

    ////////////////////////////////////////////////////////////
    // Approximate columns 2 to 7
    ////////////////////////////////////////////////////////////

    assign aha2 = approxHalfAdd(ppArray[2][0], ppArray[0][2]);

    // Generate bits merged by OR per column
    assign gen3 = pgColumns.g3[0] | pgColumns.g21;
    assign gen4 = pgColumns.g4[0] | pgColumns.g3[1];
    assign gen5 = |{pgColumns.g5[0], pgColumns.g4[1], pgColumns.g3[2]};
    assign gen6 = |{pgColumns.g6[0], pgColumns.g5[1], pgColumns.g4[2]};
    assign gen7 = |{pgColumns.g7[0], pgColumns.g6[1], pgColumns.g5[2], pgColumns.g4[3]};

    // First level on the propagate bits
    assign aha4 = approxHalfAdd(pgColumns.p4[0], pgColumns.p3[1]);
    assign afa5 = approxFullAdd(pgColumns.p5[0], pgColumns.p4[1], pgColumns.p3[2]);
    // Column 6 takes the diagonal bit 3,3
    assign pac6 = pacCompress(pgColumns.p6[0], pgColumns.p5[1],
                              pgColumns.p4[2], ppArray[3][3]);
    assign pac7 = pacCompress(pgColumns.p7[0], pgColumns.p6[1],
                              pgColumns.p5[2], pgColumns.p4[3]);

    // Second level
    assign row3 = approxFullAdd(pgColumns.p3[0], pgColumns.p21, gen3);
    assign row4 = approxFullAdd(aha4.sum, ppArray[2][2], gen4);
    assign row5 = approxFullAdd(afa5.sum, gen5, aha4.carry);
    assign row6 = approxFullAdd(pac6.sum, gen6, afa5.carry);
    assign row7 = approxFullAdd(pac7.sum, gen7, pac6.carry);

    ////////////////////////////////////////////////////////////
    // Exact columns 8 to 15
    ////////////////////////////////////////////////////////////

    // Carry of ha12 is left open
    assign ha12  = exactHalfAdd(ppArray[7][5], ppArray[5][7]);
    assign gen11 = exactHalfAdd(pgColumns.g7[4], pgColumns.g6[5]);
    assign ha11  = exactHalfAdd(pgColumns.p7[4], pgColumns.p6[5]);
    assign gen10 = exactHalfAdd(pgColumns.g7[3], pgColumns.g6[4]);
    assign fa10  = exactFullAdd(pgColumns.p7[3], pgColumns.p6[4], ppArray[5][5]);
    assign gen9  = exactFullAdd(pgColumns.g7[2], pgColumns.g6[3], pgColumns.g5[4]);
    assign fa9   = exactFullAdd(pgColumns.p7[2], pgColumns.p6[3], pgColumns.p5[4]);
    assign gen8  = exactFullAdd(pgColumns.g7[1], pgColumns.g6[2], pgColumns.g5[3]);
    assign cmp8  = exactCompress42(pgColumns.p7[1], pgColumns.p6[2], pgColumns.p5[3],
                                   ppArray[4][4], 1'b0);

    // Carries of columns 8 to 11 folded into one bit per column
    assign res8  = exactFullAdd(cmp8.carry, gen8.carry, cmp8.carryOut);
    assign res9  = exactFullAdd(fa9.carry, gen9.carry, res8.carry);
    assign res10 = exactFullAdd(fa10.carry, gen10.carry, res9.carry);
    assign res11 = exactFullAdd(ha11.carry, gen11.carry, res10.carry);
    // Column 11 generate carry enters a second time here
    assign res12 = exactHalfAdd(gen11.carry, res11.carry);

    assign row8  = exactFullAdd(cmp8.sum, gen8.sum, pac7.carry);
    assign row9  = exactFullAdd(fa9.sum, gen9.sum, res8.sum);
    assign row10 = exactFullAdd(fa10.sum, gen10.sum, res9.sum);
    assign row11 = exactFullAdd(ha11.sum, gen11.sum, res10.sum);
    assign row12 = exactFullAdd(ha12.sum, res11.sum, ppArray[6][6]);
    assign row13 = exactFullAdd(ppArray[7][6], ppArray[6][7], res12.sum);
    assign row14 = exactHalfAdd(ppArray[7][7], res12.carry);

    ////////////////////////////////////////////////////////////
    // Row assembly
    ////////////////////////////////////////////////////////////

    // Bits 0 and 1 straight from the array
    assign lowSum = {row7.sum, row6.sum, row5.sum, row4.sum, row3.sum,
                     aha2.sum, ppArray[1][0], ppArray[0][0]};
    assign lowCarry = {row6.carry, row5.carry, row4.carry, row3.carry,
                       aha2.carry, ppArray[1][1], ppArray[0][1], 1'b0};

    // Top bit of sumRow is the last carry
    assign highSum = {row14.carry, row14.sum, row13.sum, row12.sum,
                      row11.sum, row10.sum, row9.sum, row8.sum};
    assign highCarry = {1'b0, row13.carry, row12.carry, row11.carry,
                        row10.carry, row9.carry, row8.carry, row7.carry};

    assign rows.sumRow   = {highSum, lowSum};
    assign rows.carryRow = {highCarry, lowCarry};

endmodule

//--- hw/koggeStoneAdder.sv
`timescale 1ns/1ps

module koggeStoneAdder import approxMulPkg::*; #(
    parameter int Width = approxMulPkg::ProductWidth
) (
    input  rowPairT rows,
    output productT sum
);

    localparam int Levels = $clog2(Width);

    logic [Width-1:0] opA;
    logic [Width-1:0] opB;

    // Group generate and propagate per level
    logic [Levels:0][Width-1:0] gLvl;
    logic [Levels:0][Width-1:0] pLvl;

    assign opA = rows.sumRow;
    assign opB = rows.carryRow;

    // Level 0 is bitwise
    assign gLvl[0] = opA & opB;
    assign pLvl[0] = opA ^ opB;

    ////////////////////////////////////////////////////////////
    // Prefix tree
    ////////////////////////////////////////////////////////////

    for (genvar l = 1; l <= Levels; l++) begin : gLevel
        // Distance to the partner bit doubles each level
        localparam int Span = 1 << (l - 1);

        for (genvar i = 0; i < Width; i++) begin : gBit
            if (i < Span) begin : gWire
                // Group already complete
                assign gLvl[l][i] = gLvl[l-1][i];
                assign pLvl[l][i] = pLvl[l-1][i];
            end else if (i < 2 * Span) begin : gGrey
                // Group reaches bit 0 after this cell
                assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][i-Span]);
                assign pLvl[l][i] = pLvl[l-1][i];
            end else begin : gBlack
                assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][i-Span]);
                assign pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][i-Span];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Sum bits
    ////////////////////////////////////////////////////////////

    // Carry into bit i is the prefix generate of bits i-1 to 0
    // Carry out of the top bit is dropped
    assign sum = {pLvl[0][Width-1:1] ^ gLvl[Levels][Width-2:0], pLvl[0][0]};

endmodule

//--- hw/approxMultiplier.sv
`timescale 1ns/1ps

module approxMultiplier import approxMulPkg::*; #(
    parameter int OperandWidth = approxMulPkg::OperandWidth,
    parameter int ProductWidth = approxMulPkg::ProductWidth
) (
    input  logic    clk,
    input  logic    rstN,
    input  mulReqT  mulReq,
    output productT product,
    output logic    outValid
);

    // Stage 1 operands and stage 2 rows
    mulReqT    opReg;
    rowPairT   rowReg;
    logic      rowValid;

    ppArrayT   ppArray;
    pgColumnsT pgColumns;
    rowPairT   rowComb;

    ////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // Payload loads every cycle
        opReg.multiplicand <= mulReq.multiplicand;
        opReg.multiplier   <= mulReq.multiplier;
        rowReg             <= rowComb;
        // Valid bits follow the data two deep
        if (!rstN) begin
            opReg.valid <= 1'b0;
            rowValid    <= 1'b0;
        end else begin
            opReg.valid <= mulReq.valid;
            rowValid    <= opReg.valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    partialProductGen #(
        .OperandWidth(OperandWidth)
    ) uPpGen (
        .multiplicand(opReg.multiplicand),
        .multiplier  (opReg.multiplier),
        .ppArray     (ppArray),
        .pgColumns   (pgColumns)
    );

    // Reduction down to two rows
    columnReduction #(
        .ApproxTopColumn(ApproxTopColumn)
    ) uReduce (
        .ppArray  (ppArray),
        .pgColumns(pgColumns),
        .rows     (rowComb)
    );

    // Final add after the row register
    koggeStoneAdder #(
        .Width(ProductWidth)
    ) uAdder (
        .rows(rowReg),
        .sum (product)
    );

    assign outValid = rowValid;

    // Nothing comes out for two cycles after a reset cycle
    aResetQuiet: assert property (@(posedge clk) !rstN |=> !outValid ##1 !outValid);

    // Fixed two cycle latency
    aLatency: assert property (@(posedge clk) disable iff (!rstN)
        mulReq.valid |-> ##2 outValid);

endmodule

//--- dv/approxMultiplierTb.sv
`timescale 1ns/1ps

module approxMultiplierTb import approxMulPkg::*; ();

    localparam int ClockPeriod = 100;
    localparam int ResetCycles = 5;
    localparam int Latency     = 2;
    localparam int WaitLimit   = 20;

    logic    clk = 1'b0;
    logic    rstN;
    mulReqT  mulReq;
    productT product;
    logic    outValid;

    // Scoreboard of expected products and their issue cycles
    productT expQueue[$];
    int      issueQueue[$];

    int cycleCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testCount  = 0;

    approxMultiplier #(
        .OperandWidth(OperandWidth),
        .ProductWidth(ProductWidth)
    ) UUT (
        .clk     (clk),
        .rstN    (rstN),
        .mulReq  (mulReq),
        .product (product),
        .outValid(outValid)
    );

    initial begin
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    // Rising edges seen so far
    always @(posedge clk) cycleCount <= cycleCount + 1;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    function automatic operandT randomOperand();
        return operandT'($urandom());
    endfunction

    // Outputs are stable at the falling edge
    task automatic checkOutputs();
        productT expected;
        int      issued;
        if (outValid === 1'b1) begin
            if (expQueue.size() == 0) begin
                errorCount++;
                $display("Unexpected result at %0t: outValid is high with no request in flight",
                         $time);
            end else begin
                expected = expQueue.pop_front();
                issued   = issueQueue.pop_front();
                checkValue("product", 32'(product), 32'(expected));
                checkValue("outValid latency", 32'(cycleCount - issued), 32'(Latency));
            end
        end else if (outValid !== 1'b0) begin
            errorCount++;
            $display("Bad output at %0t: outValid is unknown", $time);
        end
    endtask

    // Check the outputs of one cycle, then drive the next request
    task automatic driveCycle(input logic valid, input operandT a, input operandT b,
                              input productT expected);
        @(negedge clk);
        checkOutputs();
        mulReq.valid        = valid;
        mulReq.multiplicand = a;
        mulReq.multiplier   = b;
        if (valid) begin
            expQueue.push_back(expected);
            issueQueue.push_back(cycleCount);
        end
    endtask

    task automatic idleCycle();
        driveCycle(1'b0, randomOperand(), randomOperand(), '0);
    endtask

    // Idle until every request in flight has come out
    task automatic drainPipeline();
        int waited;
        waited = 0;
        while (expQueue.size() > 0 && waited < WaitLimit) begin
            idleCycle();
            waited++;
        end
        if (expQueue.size() > 0) begin
            errorCount++;
            $display("Timeout at %0t: %0d results still missing after %0d cycles",
                     $time, expQueue.size(), WaitLimit);
            expQueue.delete();
            issueQueue.delete();
        end
    endtask

    // Single nonzero row so every cell sees at most one set input
    task automatic powerOfTwoRequest();
        operandT a;
        int      k;
        a = randomOperand();
        k = $urandom() % OperandWidth;
        if ($urandom() % 2 == 0) begin
            driveCycle(1'b1, a, operandT'(1 << k), productT'(a) << k);
        end else begin
            driveCycle(1'b1, operandT'(1 << k), a, productT'(a) << k);
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        $display("Test %s done with %0d errors", name, errorCount - errorsBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic resetTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < ResetCycles; i++) begin
            @(negedge clk);
            checkValue("outValid", 32'(outValid), 32'(0));
            // Requests during reset get dropped
            mulReq.valid        = 1'b1;
            mulReq.multiplicand = randomOperand();
            mulReq.multiplier   = randomOperand();
        end
        rstN         = 1'b1;
        mulReq.valid = 1'b0;
        for (int i = 0; i < Latency; i++) begin
            @(negedge clk);
            checkValue("outValid", 32'(outValid), 32'(0));
        end
        finishTest("reset", errorsBefore);
    endtask

    task automatic zeroTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < 9; i++) begin
            case (i % 3)
                0:       driveCycle(1'b1, '0, randomOperand(), '0);
                1:       driveCycle(1'b1, randomOperand(), '0, '0);
                default: driveCycle(1'b1, '0, '0, '0);
            endcase
        end
        drainPipeline();
        finishTest("zeroOperand", errorsBefore);
    endtask

    task automatic unitTest();
        int      errorsBefore;
        operandT a;
        errorsBefore = errorCount;
        for (int i = 0; i < 16; i++) begin
            a = randomOperand();
            driveCycle(1'b1, a, operandT'(1), productT'(a));
        end
        drainPipeline();
        finishTest("unitMultiplier", errorsBefore);
    endtask

    task automatic traceTest();
        int          errorsBefore;
        int          fd;
        int          vectorCount;
        string       line;
        logic [31:0] traceA;
        logic [31:0] traceB;
        logic [31:0] traceExp;
        errorsBefore = errorCount;
        vectorCount  = 0;
        fd = $fopen("dv/approxMulTrace.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the trace file dv/approxMulTrace.txt");
        end else begin
            // Comment and blank lines do not scan as three hex fields
            while ($fgets(line, fd) > 0) begin
                if ($sscanf(line, "%h %h %h", traceA, traceB, traceExp) == 3) begin
                    driveCycle(1'b1, operandT'(traceA), operandT'(traceB),
                               productT'(traceExp));
                    vectorCount++;
                end
            end
            $fclose(fd);
            if (vectorCount == 0) begin
                errorCount++;
                $display("The trace file holds no vectors");
            end
        end
        drainPipeline();
        finishTest("trace", errorsBefore);
    endtask

    // Back to back requests, one result per cycle
    task automatic streamTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < 24; i++) begin
            powerOfTwoRequest();
        end
        drainPipeline();
        finishTest("throughput", errorsBefore);
    endtask

    task automatic bubbleTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < 32; i++) begin
            if ($urandom() % 3 == 0) begin
                idleCycle();
            end else begin
                powerOfTwoRequest();
            end
        end
        drainPipeline();
        // Nothing more may come out
        for (int i = 0; i <= Latency; i++) begin
            idleCycle();
        end
        finishTest("bubbles", errorsBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h4871));
        rstN                = 1'b0;
        mulReq.valid        = 1'b1;
        mulReq.multiplicand = randomOperand();
        mulReq.multiplier   = randomOperand();

        resetTest();
        zeroTest();
        unitTest();
        traceTest();
        streamTest();
        bubbleTest();

        $display("Tests run: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- dv/approxMulTrace.txt
# multiplicand multiplier expected product, all hex
# products follow the approximate cell equations, not plain multiplication

# Zero operands
00 00 0000
00 ff 0000
ff 00 0000
00 5a 0000

# One operand a power of two, every column has one bit
01 01 0001
01 ff 00ff
ff 01 00ff
02 ff 01fe
ff 02 01fe
04 ab 02ac
ab 04 02ac
08 5c 02e0
3c 08 01e0
10 c3 0c30
c3 10 0c30
20 77 0ee0
e7 20 1ce0
40 99 2640
99 40 2640
80 ff 7f80
ff 80 7f80
80 80 4000

# Low columns only
03 03 0009
07 07 0035
0f 0f 00a5

# High columns only
f0 f0 e100

# Generate bit of column 7 lost in the approximate cell
ff 81 7fff
81 ff 7fff

# Every partial product set
ff ff fa05

//--- approxMultiplier.f
hw/approxMulPkg.sv
hw/approxCellPkg.sv
hw/partialProductGen.sv
hw/columnReduction.sv
hw/koggeStoneAdder.sv
hw/approxMultiplier.sv
dv/approxMultiplierTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the approximate multiplier testbench with Verilator

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log
SIM=approxMultiplierSim

verilator --binary --assert -f approxMultiplier.f --top-module approxMultiplierTb -o "$SIM"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Trace file paths are relative to the project root
./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
